// File: src/battle_pkg.sv
package battle_pkg;

	// horizontal raster in pixel clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// vertical raster in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// board placement on screen
	localparam int GRID_X0 = 160;
	localparam int GRID_Y0 = 80;
	localparam int CELL_PX = 40;
	localparam int GRID_N = 8;

	// ship layout codes
	localparam logic [1:0] LAYOUT_WATER = 2'b00;
	localparam logic [1:0] LAYOUT_MINE = 2'b01;
	localparam logic [1:0] LAYOUT_THEIRS = 2'b10;
	localparam logic [1:0] LAYOUT_BOTH = 2'b11;

	// who has fired on the cell
	localparam logic [1:0] SHOT_NONE = 2'b00;
	localparam logic [1:0] SHOT_MINE = 2'b01;
	localparam logic [1:0] SHOT_THEIRS = 2'b10;
	localparam logic [1:0] SHOT_BOTH = 2'b11;

	// 12 bit colours, 4 bits each of red green blue
	localparam logic [11:0] COL_BLACK = 12'h000;
	localparam logic [11:0] COL_EDGE = 12'h888;
	localparam logic [11:0] COL_WATER = 12'h04c;
	localparam logic [11:0] COL_SHIP = 12'h8a8;
	localparam logic [11:0] COL_MISS = 12'hfff;
	localparam logic [11:0] COL_HIT = 12'hf20;
	localparam logic [11:0] COL_CURSOR = 12'hff0;

	// counters to colour output latency
	localparam int PIPE_DEPTH = 3;

	// game logic sees the whole word, the shader sees two fields
	typedef union packed {
		logic [3:0] raw;
		struct packed {
			logic [1:0] shots;
			logic [1:0] layout;
		} fld;
	} cell_word_u;

endpackage

// File: src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing import battle_pkg::*; (
	input  logic       clk_in,
	input  logic       rst,
	output logic [9:0] hcount,
	output logic [9:0] vcount,
	output logic       hsync,
	output logic       vsync,
	output logic       de
);

	// next raster position, forced to the origin under reset
	logic [9:0] h_next;
	logic [9:0] v_next;
	logic       h_wrap;
	logic       hs_low;
	logic       vs_low;
	logic       act_next;

	// end of line marker
	assign h_wrap = (hcount == 10'(H_TOTAL - 1));

	always_comb begin
		if (rst) begin
			h_next = '0;
			v_next = '0;
		end else if (h_wrap) begin
			h_next = '0;
			// new line, wrap the frame after the last back porch line
			if (vcount == 10'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = vcount + 10'd1;
		end else begin
			h_next = hcount + 10'd1;
			v_next = vcount;
		end
	end

	// sync windows sit right after the front porch
	assign hs_low = (h_next >= 10'(H_ACTIVE + H_FRONT)) &&
		(h_next < 10'(H_ACTIVE + H_FRONT + H_SYNC));
	assign vs_low = (v_next >= 10'(V_ACTIVE + V_FRONT)) &&
		(v_next < 10'(V_ACTIVE + V_FRONT + V_SYNC));
	assign act_next = (h_next < 10'(H_ACTIVE)) && (v_next < 10'(V_ACTIVE));

	// levels are decoded from the next count so they line up with the counters
	always_ff @(posedge clk_in) begin
		hcount <= h_next;
		vcount <= v_next;
		// syncs are active low
		hsync <= !hs_low;
		vsync <= !vs_low;
		// enable covers the visible area of the raster
		de <= act_next;
	end

	// counters never leave the frame
	a_count_range: assert property (@(posedge clk_in)
		(hcount < 10'(H_TOTAL)) && (vcount < 10'(V_TOTAL)));

endmodule

// File: src/grid_locate.sv
`timescale 1ns/1ps

module grid_locate import battle_pkg::*; (
	input  logic       clk_in,
	input  logic       rst,
	input  logic [9:0] hcount,
	input  logic [9:0] vcount,
	input  logic       hsync_in,
	input  logic       vsync_in,
	input  logic       de_in,
	input  logic [9:0] cursor_x,
	input  logic [9:0] cursor_y,
	output logic [2:0] cell_x,
	output logic [2:0] cell_y,
	output logic       in_grid,
	output logic       on_edge,
	output logic       on_cursor,
	output logic       hsync,
	output logic       vsync,
	output logic       de
);

	// divide by CELL_PX through compares against its multiples
	function automatic logic [2:0] cell_index(input logic [9:0] d);
		logic [2:0] idx;
		idx = '0;
		for (int i = 1; i < GRID_N; i++) begin
			if (d >= 10'(i * CELL_PX))
				idx = 3'(i);
		end
		return idx;
	endfunction

	// offset of a position inside its cell
	function automatic logic [9:0] cell_offset(input logic [9:0] d);
		return d - 10'(cell_index(d) * CELL_PX);
	endfunction

	// positions relative to the board corner
	logic [9:0] px_rel;
	logic [9:0] py_rel;
	logic [9:0] cx_rel;
	logic [9:0] cy_rel;
	logic [9:0] px_off;
	logic [9:0] py_off;
	logic       pix_in;
	logic       cur_in;
	logic       edge_x;
	logic       edge_y;
	logic       same_cell;

	// stage 1 flags waiting for the store read
	logic s1_in_grid;
	logic s1_on_edge;
	logic s1_on_cursor;
	logic s1_hsync;
	logic s1_vsync;
	logic s1_de;

	assign px_rel = hcount - 10'(GRID_X0);
	assign py_rel = vcount - 10'(GRID_Y0);
	assign cx_rel = cursor_x - 10'(GRID_X0);
	assign cy_rel = cursor_y - 10'(GRID_Y0);
	assign px_off = cell_offset(px_rel);
	assign py_off = cell_offset(py_rel);

	// left of or above the origin wraps to a large value and fails the bound
	assign pix_in = (px_rel < 10'(GRID_N * CELL_PX)) && (py_rel < 10'(GRID_N * CELL_PX));
	assign cur_in = (cx_rel < 10'(GRID_N * CELL_PX)) && (cy_rel < 10'(GRID_N * CELL_PX));

	// first and last pixel of a cell on either axis
	assign edge_x = (px_off == 10'd0) || (px_off == 10'(CELL_PX - 1));
	assign edge_y = (py_off == 10'd0) || (py_off == 10'(CELL_PX - 1));

	assign same_cell = (cell_index(px_rel) == cell_index(cx_rel)) &&
		(cell_index(py_rel) == cell_index(cy_rel));

	// stage 1 address goes out to the store straight from here
	always_ff @(posedge clk_in) begin
		cell_x <= cell_index(px_rel);
		cell_y <= cell_index(py_rel);
		s1_in_grid <= pix_in;
		s1_on_edge <= edge_x || edge_y;
		s1_on_cursor <= same_cell && cur_in;
	end

	// stage 2 realigns the flags with rd_cell
	always_ff @(posedge clk_in) begin
		in_grid <= s1_in_grid;
		on_edge <= s1_on_edge;
		on_cursor <= s1_on_cursor;
	end

	// sync and enable travel alongside, idle levels under reset
	always_ff @(posedge clk_in) begin
		if (rst) begin
			s1_hsync <= 1'b1;
			s1_vsync <= 1'b1;
			s1_de <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
		end else begin
			s1_hsync <= hsync_in;
			s1_vsync <= vsync_in;
			s1_de <= de_in;
			hsync <= s1_hsync;
			vsync <= s1_vsync;
			de <= s1_de;
		end
	end

endmodule

// File: src/cell_store.sv
`timescale 1ns/1ps

module cell_store import battle_pkg::*; (
	input  logic       clk_in,
	input  logic       rst,
	// pixel side read address
	input  logic [2:0] cell_x,
	input  logic [2:0] cell_y,
	output cell_word_u rd_cell,
	// game side write port, taken on every cycle
	input  logic       cell_we,
	input  logic [2:0] cell_wx,
	input  logic [2:0] cell_wy,
	input  cell_word_u cell_wdata
);

	// one word per cell, row major
	cell_word_u cells [GRID_N * GRID_N];

	// row times 8 plus column
	logic [5:0] rd_idx;
	logic [5:0] wr_idx;

	assign rd_idx = {cell_y, cell_x};
	assign wr_idx = {cell_wy, cell_wx};

	// a reset board is all water with no shot fired
	always_ff @(posedge clk_in) begin
		if (rst) begin
			for (int i = 0; i < GRID_N * GRID_N; i++)
				cells[i].raw <= {SHOT_NONE, LAYOUT_WATER};
		end else if (cell_we) begin
			cells[wr_idx] <= cell_wdata;
		end
	end

	// registered read
	// same cell written this cycle still reads the old word
	always_ff @(posedge clk_in) begin
		rd_cell <= cells[rd_idx];
	end

	// the game must hold off while the board is being cleared
	a_no_write_in_reset: assert property (@(posedge clk_in)
		rst |-> !cell_we);

endmodule

// File: src/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader import battle_pkg::*; (
	input  logic        clk_in,
	input  logic        rst,
	input  cell_word_u  rd_cell,
	input  logic        in_grid,
	input  logic        on_edge,
	input  logic        on_cursor,
	input  logic        hsync_in,
	input  logic        vsync_in,
	input  logic        de_in,
	output logic [11:0] rgb,
	output logic        hsync,
	output logic        vsync,
	output logic        de
);

	// decoded cell contents
	logic        my_shot;
	logic        their_ship;
	logic        my_ship;
	logic [11:0] cell_col;
	logic [11:0] pix_col;

	// did I fire here
	always_comb begin
		case (rd_cell.fld.shots)
			SHOT_MINE, SHOT_BOTH: my_shot = 1'b1;
			SHOT_NONE, SHOT_THEIRS: my_shot = 1'b0;
			default: my_shot = 1'b0;
		endcase
	end

	// which ships sit on the cell
	always_comb begin
		their_ship = 1'b0;
		my_ship = 1'b0;
		case (rd_cell.fld.layout)
			LAYOUT_MINE: my_ship = 1'b1;
			LAYOUT_THEIRS: their_ship = 1'b1;
			LAYOUT_BOTH: begin
				my_ship = 1'b1;
				their_ship = 1'b1;
			end
			LAYOUT_WATER: ;
			default: ;
		endcase
	end

	// their ships stay hidden until I hit them
	assign cell_col = my_shot ? (their_ship ? COL_HIT : COL_MISS) :
		(my_ship ? COL_SHIP : COL_WATER);

	// blanking first, then cursor border, plain border, cell body
	always_comb begin
		if (!de_in || !in_grid)
			pix_col = COL_BLACK;
		else if (on_edge && on_cursor)
			pix_col = COL_CURSOR;
		else if (on_edge)
			pix_col = COL_EDGE;
		else
			pix_col = cell_col;
	end

	always_ff @(posedge clk_in) begin
		if (rst) begin
			rgb <= COL_BLACK;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
		end else begin
			rgb <= pix_col;
			hsync <= hsync_in;
			vsync <= vsync_in;
			de <= de_in;
		end
	end

	// nothing is driven onto the screen while blanked
	a_black_when_blank: assert property (@(posedge clk_in)
		!de |-> (rgb == COL_BLACK));

endmodule

// File: src/battle_display.sv
`timescale 1ns/1ps

module battle_display import battle_pkg::*; (
	input  logic       clk_in,
	input  logic       rst,
	// mouse position in screen pixels
	input  logic [9:0] cursor_x,
	input  logic [9:0] cursor_y,
	// game logic cell writes
	input  logic       cell_we,
	input  logic [2:0] cell_wx,
	input  logic [2:0] cell_wy,
	input  logic [3:0] cell_wdata,
	// to the VGA connector
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic       hsync,
	output logic       vsync,
	output logic       de
);

	// raster counters and their levels
	logic [9:0] hcount;
	logic [9:0] vcount;
	logic       t_hsync;
	logic       t_vsync;
	logic       t_de;

	// store address and realigned flags
	logic [2:0] cell_x;
	logic [2:0] cell_y;
	logic       in_grid;
	logic       on_edge;
	logic       on_cursor;
	logic       g_hsync;
	logic       g_vsync;
	logic       g_de;
	cell_word_u rd_cell;

	vga_timing vga_timing_i (
		.clk_in(clk_in),
		.rst(rst),
		.hcount(hcount),
		.vcount(vcount),
		.hsync(t_hsync),
		.vsync(t_vsync),
		.de(t_de)
	);

	grid_locate grid_locate_i (
		.clk_in(clk_in),
		.rst(rst),
		.hcount(hcount),
		.vcount(vcount),
		.hsync_in(t_hsync),
		.vsync_in(t_vsync),
		.de_in(t_de),
		.cursor_x(cursor_x),
		.cursor_y(cursor_y),
		.cell_x(cell_x),
		.cell_y(cell_y),
		.in_grid(in_grid),
		.on_edge(on_edge),
		.on_cursor(on_cursor),
		.hsync(g_hsync),
		.vsync(g_vsync),
		.de(g_de)
	);

	// raw write word lands in the union port as is
	cell_store cell_store_i (
		.clk_in(clk_in),
		.rst(rst),
		.cell_x(cell_x),
		.cell_y(cell_y),
		.rd_cell(rd_cell),
		.cell_we(cell_we),
		.cell_wx(cell_wx),
		.cell_wy(cell_wy),
		.cell_wdata(cell_wdata)
	);

	// colour splits into the three connector channels
	pixel_shader pixel_shader_i (
		.clk_in(clk_in),
		.rst(rst),
		.rd_cell(rd_cell),
		.in_grid(in_grid),
		.on_edge(on_edge),
		.on_cursor(on_cursor),
		.hsync_in(g_hsync),
		.vsync_in(g_vsync),
		.de_in(g_de),
		.rgb({red, green, blue}),
		.hsync(hsync),
		.vsync(vsync),
		.de(de)
	);

endmodule

// File: tb/battle_display_tb.sv
`timescale 1ns/1ps

module battle_display_tb import battle_pkg::*; ();

	localparam int RST_CYCLES = 16;
	localparam int CLK_NS = 20;
	// first visible line comes after the sync and back porch lines
	localparam int LINES_BEFORE_ACTIVE = V_SYNC + V_BACK;
	// test slots, one probe slot per frame from T_PROBE upward
	localparam int T_RESET = 0;
	localparam int T_SYNC = 1;
	localparam int T_BLANK = 2;
	localparam int T_PROBE = 3;

	logic clk_in, rst, cell_we;
	logic [9:0] cursor_x, cursor_y;
	logic [2:0] cell_wx, cell_wy;
	logic [3:0] cell_wdata, red, green, blue;
	logic hsync, vsync, de;
	logic [11:0] rgb;

	// stimulus and expected colours from the data file
	logic [9:0] cur_x_q[$], cur_y_q[$];
	logic [2:0] wr_x_q[$], wr_y_q[$];
	logic [3:0] wr_d_q[$];
	int p_x[$], p_y[$], p_frame[$];
	logic [11:0] p_exp[$];
	bit p_seen[$];
	int probe_at[int];
	int test_checks[8];
	int test_errs[8];
	int bad_lines = 0;
	bit loaded = 1'b0;
	bit running = 1'b0;

	// raster position rebuilt from the outputs
	int frame = 0;
	int line_cnt = LINES_BEFORE_ACTIVE;
	int x_pos = 0;
	int hs_run = 0;
	int de_run = 0;
	int vs_lines = 0;
	int key, idx;
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	logic prev_de = 1'b0;

	assign rgb = {red, green, blue};

	battle_display battle_display_i (
		.clk_in(clk_in),
		.rst(rst),
		.cursor_x(cursor_x),
		.cursor_y(cursor_y),
		.cell_we(cell_we),
		.cell_wx(cell_wx),
		.cell_wy(cell_wy),
		.cell_wdata(cell_wdata),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync(hsync),
		.vsync(vsync),
		.de(de)
	);

	initial begin
		clk_in = 1'b0;
		forever #(CLK_NS / 2) clk_in = ~clk_in;
	end

	task automatic check_value(input int test, input string name, input logic [31:0] got,
			input logic [31:0] exp);
		test_checks[test]++;
		if (got !== exp) begin
			test_errs[test]++;
			$display("error: %s got %0h expected %0h", name, got, exp);
		end
	endtask

	// unique slot per frame, line and column
	function automatic int probe_key(input int f, input int px, input int py);
		return f * 1048576 + py * 1024 + px;
	endfunction

	// cursor of a frame sits somewhere on the board
	function automatic bit cursor_on_board(input int f);
		return (cur_x_q[f] >= GRID_X0) && (cur_x_q[f] < GRID_X0 + GRID_N * CELL_PX) &&
			(cur_y_q[f] >= GRID_Y0) && (cur_y_q[f] < GRID_Y0 + GRID_N * CELL_PX);
	endfunction

	task automatic load_testdata();
		int fd;
		int n;
		string line;
		string kind;
		logic [31:0] a, b, c;
		fd = $fopen("tb/battle_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/battle_testdata.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
			// every cursor line opens the next frame
			if (kind == "c") begin
				cur_x_q.push_back(a[9:0]);
				cur_y_q.push_back(b[9:0]);
			end else if (kind == "w") begin
				wr_x_q.push_back(a[2:0]);
				wr_y_q.push_back(b[2:0]);
				wr_d_q.push_back(c[3:0]);
			end else if (kind == "p") begin
				probe_at[probe_key(cur_x_q.size() - 1, int'(a), int'(b))] = p_x.size();
				p_x.push_back(int'(a));
				p_y.push_back(int'(b));
				p_frame.push_back(cur_x_q.size() - 1);
				p_exp.push_back(c[11:0]);
				p_seen.push_back(1'b0);
			end else begin
				$display("unknown line in test data: %s", line);
				bad_lines++;
			end
		end
		$fclose(fd);
	endtask

	task automatic report_test(input int test, input string label);
		$display("test %s: %0d checks, %0d errors", label, test_checks[test], test_errs[test]);
	endtask

	// a probe that never came up on screen counts against its frame
	task automatic check_probes_seen(input int f);
		for (int i = 0; i < p_x.size(); i++) begin
			if (p_frame[i] == f && !p_seen[i]) begin
				test_errs[T_PROBE + f]++;
				$display("pixel (%0d,%0d) in frame %0d was never displayed", p_x[i], p_y[i], f);
			end
		end
	endtask

	// outputs move on the rising edge, so look at them on the falling one
	always @(negedge clk_in) begin
		if (running) begin
			if (prev_vs && !vsync) begin
				frame++;
				line_cnt = 0;
				vs_lines = 0;
			end
			if (!prev_vs && vsync)
				check_value(T_SYNC, "vsync low lines", vs_lines, V_SYNC);
			// one hsync fall per line
			if (prev_hs && !hsync) begin
				line_cnt++;
				if (!vsync)
					vs_lines++;
			end
			if (!hsync) begin
				hs_run++;
			end else if (!prev_hs) begin
				check_value(T_SYNC, "hsync low cycles", hs_run, H_SYNC);
				hs_run = 0;
			end
			if (de) begin
				key = probe_key(frame, x_pos, line_cnt - LINES_BEFORE_ACTIVE);
				if (probe_at.exists(key)) begin
					idx = probe_at[key];
					p_seen[idx] = 1'b1;
					check_value(T_PROBE + frame, $sformatf("rgb at (%0d,%0d)", x_pos,
						line_cnt - LINES_BEFORE_ACTIVE), 32'(rgb), 32'(p_exp[idx]));
				end
				// with the cursor off the board no pixel takes the cursor colour
				if (frame < cur_x_q.size() && !cursor_on_board(frame))
					check_value(T_PROBE + frame, "rgb is cursor colour",
						32'(rgb == COL_CURSOR), 32'h0);
				x_pos++;
				de_run++;
			end else begin
				if (prev_de) begin
					check_value(T_SYNC, "de high cycles", de_run, H_ACTIVE);
					de_run = 0;
					x_pos = 0;
				end
				// blanked cycles are black
				check_value(T_BLANK, "rgb while blanked", 32'(rgb), 32'h0);
			end
			prev_hs = hsync;
			prev_vs = vsync;
			prev_de = de;
		end
	end

	task automatic run_frames();
		int total_checks;
		int total_errs;
		cursor_x = cur_x_q[0];
		cursor_y = cur_y_q[0];
		repeat (RST_CYCLES - 1) @(posedge clk_in);
		// idle levels while still in reset
		@(negedge clk_in);
		check_value(T_RESET, "hsync", 32'(hsync), 32'h1);
		check_value(T_RESET, "vsync", 32'(vsync), 32'h1);
		check_value(T_RESET, "de", 32'(de), 32'h0);
		check_value(T_RESET, "rgb", 32'(rgb), 32'h0);
		report_test(T_RESET, "reset state");
		@(posedge clk_in);
		rst <= 1'b0;
		running = 1'b1;
		// board writes land long before the grid rows
		for (int i = 0; i < wr_x_q.size(); i++) begin
			@(posedge clk_in);
			cell_we <= 1'b1;
			cell_wx <= wr_x_q[i];
			cell_wy <= wr_y_q[i];
			cell_wdata <= wr_d_q[i];
		end
		@(posedge clk_in);
		cell_we <= 1'b0;
		for (int f = 0; f < cur_x_q.size(); f++) begin
			// new cursor during vertical blanking
			if (f > 0) begin
				@(posedge clk_in);
				cursor_x <= cur_x_q[f];
				cursor_y <= cur_y_q[f];
			end
			@(negedge vsync);
			check_probes_seen(f);
			report_test(T_PROBE + f, $sformatf("probes frame %0d", f));
		end
		report_test(T_SYNC, "sync timing");
		report_test(T_BLANK, "blanking");
		total_checks = 0;
		total_errs = 0;
		for (int t = 0; t < T_PROBE + cur_x_q.size(); t++) begin
			total_checks += test_checks[t];
			total_errs += test_errs[t];
		end
		$display("summary: %0d checks, %0d errors", total_checks, total_errs);
		if (total_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		cursor_x = '0;
		cursor_y = '0;
		cell_we = 1'b0;
		cell_wx = '0;
		cell_wy = '0;
		cell_wdata = '0;
		load_testdata();
		loaded = 1'b1;
		if (bad_lines != 0 || cur_x_q.size() == 0 || cur_x_q.size() > 8 - T_PROBE) begin
			$display("test data must be well formed and hold one to five cursor lines");
			$display("Done: errors found");
			$finish;
		end else begin
			run_frames();
		end
	end

	// reset, every frame of the test and a few spare lines
	initial begin
		longint limit_ns;
		wait (loaded);
		limit_ns = longint'(RST_CYCLES + cur_x_q.size() * H_TOTAL * V_TOTAL + 4 * H_TOTAL) *
			CLK_NS;
		#(limit_ns);
		$display("timeout: the display did not finish %0d frames in time", cur_x_q.size());
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: tb/battle_testdata.txt
# c: cursor x y in pixels, w: cell x y word {shots,layout}, p: pixel x y expected rgb
# all values hex, each c line starts the next frame
c 12c 0fa
w 1 1 1
w 2 3 4
w 5 2 6
w 6 6 2
p 000 000 000
p 09f 0c8 000
p 1e0 0c8 000
p 12c 190 000
p 0a0 050 888
p 0b4 064 04c
p 0c7 064 888
p 1cc 17c 04c
p 0dc 08c 8a8
p 104 0dc fff
p 17c 0b4 f20
p 1a4 154 04c
p 118 104 ff0
p 13f 0fa ff0
p 12c 0f0 ff0
p 12c 104 04c
p 140 104 888
c 028 01e
p 118 104 888
p 12c 0f0 888
p 12c 104 04c

// File: compile.f
src/battle_pkg.sv
src/vga_timing.sv
src/grid_locate.sv
src/cell_store.sv
src/pixel_shader.sv
src/battle_display.sv
tb/battle_display_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the battle display testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module battle_display_tb \
	-f compile.f -o battle_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/battle_sim)
echo "$out"
echo "$out" | grep -qxF "Done: no errors" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
